// ==== src/id_ex_reg.sv ====
// ID/EX pipeline register, loads a bubble while the stage is stalled
`default_nettype none
`timescale 1ns/1ps

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     op1_i,
    input  id_pkg::word_t     op2_i,
    output id_pkg::id_ex_t    id_ex_o
);
    import id_pkg::*;

    localparam id_ex_t BUBBLE = '{
        pc: '0, inst: '0, aluop: ALU_NONE, alusel: SEL_NONE,
        op1: '0, op2: '0, wd: '0, wreg: 1'b0, inst_ok: 1'b0
    };

    id_ex_t next_d;

    always_comb begin
        next_d.pc      = pc_i;
        next_d.inst    = inst_i;
        next_d.aluop   = ctrl_i.aluop;
        next_d.alusel  = ctrl_i.alusel;
        next_d.op1     = op1_i;
        next_d.op2     = op2_i;
        next_d.wd      = ctrl_i.wd;
        next_d.wreg    = ctrl_i.wreg;
        next_d.inst_ok = ctrl_i.inst_ok;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= BUBBLE;
        end else begin
            id_ex_o <= stall_i ? BUBBLE : next_d;   // held inst redecoded next cycle
        end
    end

endmodule

`default_nettype wire

// ==== src/id_pkg.sv ====
// RV32I decode stage shared widths, opcodes, ALU encodings and stage structs
`default_nettype none

package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // OP and OP-IMM share these
    localparam logic [2:0] F3_ADD  = 3'b000;    // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // srl/sra, funct7[5] picks
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;

    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [4:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_LUI, ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NONE, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_COMPARE, SEL_LOAD, SEL_STORE
    } alusel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_u;

    typedef struct packed {
        logic      re;
        reg_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic      we;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        logic      wreg;
        reg_addr_t wd;
        rd_req_t   rs1;
        rd_req_t   rs2;
        word_t     imm1;
        word_t     imm2;
        logic      inst_ok;
    } dec_ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     op1;
        word_t     op2;
        reg_addr_t wd;
        logic      wreg;
        logic      inst_ok;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== src/id_stage_top.sv ====
// RV32I decode stage: decoder, two operand forwarders and the ID/EX register
`default_nettype none
`timescale 1ns/1ps

module id_stage_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  id_pkg::word_t    pc_i,
    input  id_pkg::word_t    inst_i,
    input  id_pkg::word_t    rf_rdata1_i,
    input  id_pkg::word_t    rf_rdata2_i,
    input  id_pkg::fwd_src_t ex_fwd_i,
    input  id_pkg::fwd_src_t mem_fwd_i,
    input  id_pkg::aluop_e   ex_aluop_i,
    output id_pkg::rd_req_t  rs1_rd_o,
    output id_pkg::rd_req_t  rs2_rd_o,
    output logic             stall_o,
    output id_pkg::id_ex_t   id_ex_o
);
    import id_pkg::*;

    dec_ctrl_t ctrl;
    word_t     op1;
    word_t     op2;
    logic      load_use1;
    logic      load_use2;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .pc_i   (pc_i),
        .ctrl_o (ctrl)
    );

    operand_forward u_fwd1 (
        .rd_req_i   (ctrl.rs1),
        .rf_rdata_i (rf_rdata1_i),
        .imm_i      (ctrl.imm1),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .ex_aluop_i (ex_aluop_i),
        .operand_o  (op1),
        .load_use_o (load_use1)
    );

    operand_forward u_fwd2 (
        .rd_req_i   (ctrl.rs2),
        .rf_rdata_i (rf_rdata2_i),
        .imm_i      (ctrl.imm2),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .ex_aluop_i (ex_aluop_i),
        .operand_o  (op2),
        .load_use_o (load_use2)
    );

    assign rs1_rd_o = ctrl.rs1;
    assign rs2_rd_o = ctrl.rs2;
    assign stall_o  = load_use1 | load_use2;    // same-cycle back-pressure to fetch

    id_ex_reg u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_o),
        .pc_i    (pc_i),
        .inst_i  (inst_i),
        .ctrl_i  (ctrl),
        .op1_i   (op1),
        .op2_i   (op2),
        .id_ex_o (id_ex_o)
    );

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
// RV32I instruction decoder producing control, read requests and immediates
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::inst_u     inst_i,
    input  id_pkg::word_t     pc_i,
    output id_pkg::dec_ctrl_t ctrl_o
);
    import id_pkg::*;

    word_t   imm_i_sext;
    word_t   imm_shamt;
    word_t   imm_upper;
    logic    alt;
    aluop_e  arith_op;
    alusel_e arith_sel;

    assign imm_i_sext = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_shamt  = {{(XLEN-REG_AW){1'b0}}, inst_i.r.rs2};    // shamt sits in rs2 field
    assign imm_upper  = {inst_i.u.imm, 12'b0};
    assign alt        = inst_i.r.funct7[5];                       // sub / sra select

    // function decode common to OP and OP-IMM
    always_comb begin
        case (inst_i.r.funct3)
            F3_ADD: begin
                arith_op  = ALU_ADD;
                arith_sel = SEL_ARITH;
            end
            F3_SLL: begin
                arith_op  = ALU_SLL;
                arith_sel = SEL_SHIFT;
            end
            F3_SLT: begin
                arith_op  = ALU_SLT;
                arith_sel = SEL_COMPARE;
            end
            F3_SLTU: begin
                arith_op  = ALU_SLTU;
                arith_sel = SEL_COMPARE;
            end
            F3_XOR: begin
                arith_op  = ALU_XOR;
                arith_sel = SEL_LOGIC;
            end
            F3_SR: begin
                arith_op  = alt ? ALU_SRA : ALU_SRL;
                arith_sel = SEL_SHIFT;
            end
            F3_OR: begin
                arith_op  = ALU_OR;
                arith_sel = SEL_LOGIC;
            end
            default: begin
                arith_op  = ALU_AND;
                arith_sel = SEL_LOGIC;
            end
        endcase
    end

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.aluop   = ALU_NONE;
        ctrl_o.alusel  = SEL_NONE;
        ctrl_o.inst_ok = 1'b1;

        case (inst_i.r.opcode)
            OPC_LUI: begin
                ctrl_o.aluop  = ALU_LUI;
                ctrl_o.alusel = SEL_SHIFT;
                ctrl_o.wreg   = 1'b1;
                ctrl_o.imm2   = imm_upper;
            end
            OPC_AUIPC: begin
                ctrl_o.aluop  = ALU_ADD;
                ctrl_o.alusel = SEL_ARITH;
                ctrl_o.wreg   = 1'b1;
                ctrl_o.imm1   = pc_i;
                ctrl_o.imm2   = imm_upper;
            end
            OPC_OP_IMM: begin
                ctrl_o.aluop  = arith_op;
                ctrl_o.alusel = arith_sel;
                ctrl_o.wreg   = 1'b1;
                ctrl_o.rs1.re = 1'b1;
                ctrl_o.imm2   = (arith_sel == SEL_SHIFT) ? imm_shamt : imm_i_sext;
            end
            OPC_OP: begin
                ctrl_o.aluop  = (inst_i.r.funct3 == F3_ADD && alt) ? ALU_SUB : arith_op;
                ctrl_o.alusel = arith_sel;
                ctrl_o.wreg   = 1'b1;
                ctrl_o.rs1.re = 1'b1;
                ctrl_o.rs2.re = 1'b1;
            end
            OPC_LOAD: begin
                case (inst_i.i.funct3)
                    F3_LB:   ctrl_o.aluop = ALU_LB;
                    F3_LH:   ctrl_o.aluop = ALU_LH;
                    F3_LW:   ctrl_o.aluop = ALU_LW;
                    F3_LBU:  ctrl_o.aluop = ALU_LBU;
                    F3_LHU:  ctrl_o.aluop = ALU_LHU;
                    default: ctrl_o.inst_ok = 1'b0;
                endcase
                ctrl_o.alusel = SEL_LOAD;
                ctrl_o.wreg   = 1'b1;
                ctrl_o.rs1.re = 1'b1;
            end
            OPC_STORE: begin
                case (inst_i.s.funct3)
                    F3_SB:   ctrl_o.aluop = ALU_SB;
                    F3_SH:   ctrl_o.aluop = ALU_SH;
                    F3_SW:   ctrl_o.aluop = ALU_SW;
                    default: ctrl_o.inst_ok = 1'b0;
                endcase
                ctrl_o.alusel = SEL_STORE;
                ctrl_o.rs1.re = 1'b1;
                ctrl_o.rs2.re = 1'b1;
            end
            OPC_BRANCH: begin
                case (inst_i.r.funct3)
                    F3_BEQ:  ctrl_o.aluop = ALU_BEQ;
                    F3_BNE:  ctrl_o.aluop = ALU_BNE;
                    F3_BLT:  ctrl_o.aluop = ALU_BLT;
                    F3_BGE:  ctrl_o.aluop = ALU_BGE;
                    F3_BLTU: ctrl_o.aluop = ALU_BLTU;
                    F3_BGEU: ctrl_o.aluop = ALU_BGEU;
                    default: ctrl_o.inst_ok = 1'b0;
                endcase
                ctrl_o.rs1.re = 1'b1;
                ctrl_o.rs2.re = 1'b1;
            end
            default: ctrl_o.inst_ok = 1'b0;
        endcase

        if (!ctrl_o.inst_ok) begin
            ctrl_o         = '0;        // nothing issued for an illegal word
            ctrl_o.aluop   = ALU_NONE;
            ctrl_o.alusel  = SEL_NONE;
        end

        ctrl_o.wd       = ctrl_o.wreg ? inst_i.u.rd : '0;
        ctrl_o.rs1.addr = ctrl_o.rs1.re ? inst_i.s.rs1 : '0;
        ctrl_o.rs2.addr = ctrl_o.rs2.re ? inst_i.s.rs2 : '0;
    end

endmodule

`default_nettype wire

// ==== src/operand_forward.sv ====
// source operand select with EX/MEM forwarding and load-use detection
`default_nettype none
`timescale 1ns/1ps

module operand_forward (
    input  id_pkg::rd_req_t  rd_req_i,
    input  id_pkg::word_t    rf_rdata_i,
    input  id_pkg::word_t    imm_i,
    input  id_pkg::fwd_src_t ex_fwd_i,
    input  id_pkg::fwd_src_t mem_fwd_i,
    input  id_pkg::aluop_e   ex_aluop_i,
    output id_pkg::word_t    operand_o,
    output logic             load_use_o
);
    import id_pkg::*;

    logic ex_is_load;
    logic ex_hit;
    logic mem_hit;

    assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
    assign ex_hit     = ex_fwd_i.we && (ex_fwd_i.wd == rd_req_i.addr);
    assign mem_hit    = mem_fwd_i.we && (mem_fwd_i.wd == rd_req_i.addr);

    // load data not ready until mem stage
    assign load_use_o = rd_req_i.re && ex_is_load && (ex_fwd_i.wd == rd_req_i.addr);

    always_comb begin
        if (!rd_req_i.re) begin
            operand_o = imm_i;
        end else if (load_use_o) begin
            operand_o = '0;                     // dropped, stage bubbles
        end else if (rd_req_i.addr == '0) begin
            operand_o = '0;                     // x0
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;         // youngest result first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/id_pkg.sv
src/inst_decoder.sv
src/operand_forward.sv
src/id_ex_reg.sv
src/id_stage_top.sv
verif/id_stage_props.sv
verif/tb_id_stage.sv

// ==== verif/id_stage_props.sv ====
// decode stage properties on stall bubbles, reset state and stall cause
`default_nettype none
`timescale 1ns/1ps

module id_stage_props (
    input logic            clk,
    input logic            rst_n_i,
    input logic            stall_o,
    input id_pkg::rd_req_t rs1_rd_o,
    input id_pkg::rd_req_t rs2_rd_o,
    input id_pkg::id_ex_t  id_ex_o
);
    import id_pkg::*;

    property stall_then_bubble;
        @(posedge clk) disable iff (!rst_n_i)
        stall_o |=> (id_ex_o.aluop == ALU_NONE && id_ex_o.alusel == SEL_NONE && id_ex_o == '0);
    endproperty

    property no_write_in_reset;
        @(posedge clk) !rst_n_i |-> !id_ex_o.wreg;
    endproperty

    property stall_needs_read;
        @(posedge clk) disable iff (!rst_n_i)
        !(rs1_rd_o.re || rs2_rd_o.re) |-> !stall_o;    // hazard only on a real source
    endproperty

    a_stall_bubble: assert property (stall_then_bubble)
        else $error("stall_o not followed by a bubble on id_ex_o");
    a_reset_wreg: assert property (no_write_in_reset)
        else $error("id_ex_o.wreg set during reset");
    a_stall_read: assert property (stall_needs_read)
        else $error("stall_o high with no read request enabled");

endmodule

bind id_stage_top id_stage_props u_props (.*);

`default_nettype wire

// ==== verif/tb_id_stage.sv ====
// testbench for the RV32I decode stage, LFSR and directed stimulus against a reference decode
`default_nettype none
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    localparam int NUM_PLAIN   = 300;
    localparam int NUM_FWD     = 250;
    localparam int CYCLE_LIMIT = 1000;    // reset + ~600 vectors + margin
    localparam int W           = $bits(id_ex_t);

    typedef struct packed {
        id_ex_t  ex;
        rd_req_t rs1;
        rd_req_t rs2;
        logic    stall;
    } expect_t;

    localparam fwd_src_t NO_FWD = '0;

    logic        clk = 1'b0;
    logic        rst_n;
    word_t       pc;
    word_t       inst;
    word_t       rf_rdata1;
    word_t       rf_rdata2;
    fwd_src_t    ex_fwd;
    fwd_src_t    mem_fwd;
    aluop_e      ex_aluop;
    rd_req_t     rs1_rd;
    rd_req_t     rs2_rd;
    logic        stall;
    id_ex_t      id_ex;
    logic [31:0] lfsr = 32'hf6ae_7d2a;
    expect_t     cur_exp;
    expect_t     prev_exp;
    logic        cur_v = 1'b0;
    logic        prev_v = 1'b0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;

    id_stage_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .pc_i        (pc),
        .inst_i      (inst),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .ex_aluop_i  (ex_aluop),
        .rs1_rd_o    (rs1_rd),
        .rs2_rd_o    (rs2_rd),
        .stall_o     (stall),
        .id_ex_o     (id_ex)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32,22,2,1
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t rf_hash(input reg_addr_t a);
        return ({a, 27'h0} ^ ({27'h0, a} * 32'h0105_1a3b)) ^ 32'h3c96_a5e1;
    endfunction

    assign rf_rdata1 = rf_hash(rs1_rd.addr);    // register file model
    assign rf_rdata2 = rf_hash(rs2_rd.addr);

    function automatic fwd_src_t make_fwd(input logic we, input reg_addr_t wd, input word_t d);
        fwd_src_t f;
        f.we    = we;
        f.wd    = wd;
        f.wdata = d;
        return f;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // random legal LUI, AUIPC, OP-IMM or OP word
    function automatic word_t gen_inst(input logic narrow);
        logic [1:0]  kind;
        logic [2:0]  f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic        alt;
        logic [11:0] imm;
        logic [6:0]  f7;
        kind = 2'(take_bits(2));
        f3   = 3'(take_bits(3));
        rd   = 5'(take_bits(5));
        rs1  = narrow ? 5'(take_bits(2)) : 5'(take_bits(5));    // narrow hits x0..x3
        rs2  = narrow ? 5'(take_bits(2)) : 5'(take_bits(5));
        alt  = 1'(take_bits(1));
        imm  = 12'(take_bits(12));
        f7   = (f3 == F3_ADD || f3 == F3_SR) ? {1'b0, alt, 5'b0} : 7'b0;
        if (f3 == F3_SLL || f3 == F3_SR)
            imm = {f7, rs2};    // shift forms
        case (kind)
            2'd0:    return enc_i(imm, rs1, f3, rd, OPC_LUI);
            2'd1:    return enc_i(imm, rs1, f3, rd, OPC_AUIPC);
            2'd2:    return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            default: return enc_r(f7, rs2, rs1, f3, rd, OPC_OP);
        endcase
    endfunction

    function automatic word_t forward_ref(input logic re, input reg_addr_t a, input word_t imm,
                                          input fwd_src_t exf, input fwd_src_t memf,
                                          input aluop_e exop, output logic hz);
        logic is_load;
        is_load = exop inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
        hz      = re && is_load && (exf.wd == a);
        if (!re)
            return imm;
        if (hz || a == '0)
            return '0;
        if (exf.we && exf.wd == a)
            return exf.wdata;
        if (memf.we && memf.wd == a)
            return memf.wdata;
        return rf_hash(a);
    endfunction

    function automatic expect_t expected_decode(input word_t pc_v, input word_t w,
                                                input fwd_src_t exf, input fwd_src_t memf,
                                                input aluop_e exop);
        expect_t    r;
        logic [4:0] op;
        logic [2:0] sel;
        logic [2:0] f3;
        logic       wreg;
        logic       ok;
        logic       use1;
        logic       use2;
        logic       hz1;
        logic       hz2;
        word_t      imm1;
        word_t      imm2;
        op   = ALU_NONE;
        sel  = SEL_NONE;
        f3   = w[14:12];
        wreg = 1'b0;
        ok   = 1'b1;
        use1 = 1'b0;
        use2 = 1'b0;
        imm1 = '0;
        imm2 = '0;
        case (w[6:0])
            OPC_LUI: begin
                {op, sel, wreg} = {ALU_LUI, SEL_SHIFT, 1'b1};
                imm2 = {w[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                {op, sel, wreg} = {ALU_ADD, SEL_ARITH, 1'b1};
                imm1 = pc_v;
                imm2 = {w[31:12], 12'b0};
            end
            OPC_OP_IMM, OPC_OP: begin
                {wreg, use1, use2} = {2'b11, w[6:0] == OPC_OP};
                case (f3)
                    3'd0:    {op, sel} = {(use2 && w[30]) ? ALU_SUB : ALU_ADD, SEL_ARITH};
                    3'd1:    {op, sel} = {ALU_SLL, SEL_SHIFT};
                    3'd2:    {op, sel} = {ALU_SLT, SEL_COMPARE};
                    3'd3:    {op, sel} = {ALU_SLTU, SEL_COMPARE};
                    3'd4:    {op, sel} = {ALU_XOR, SEL_LOGIC};
                    3'd5:    {op, sel} = {w[30] ? ALU_SRA : ALU_SRL, SEL_SHIFT};
                    3'd6:    {op, sel} = {ALU_OR, SEL_LOGIC};
                    default: {op, sel} = {ALU_AND, SEL_LOGIC};
                endcase
                if (!use2)
                    imm2 = (sel == SEL_SHIFT) ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
            end
            OPC_LOAD: begin
                {wreg, use1, sel} = {2'b11, SEL_LOAD};
                case (f3)
                    3'd0:    op = ALU_LB;
                    3'd1:    op = ALU_LH;
                    3'd2:    op = ALU_LW;
                    3'd4:    op = ALU_LBU;
                    3'd5:    op = ALU_LHU;
                    default: ok = 1'b0;
                endcase
            end
            OPC_STORE: begin
                {use1, use2, sel} = {2'b11, SEL_STORE};
                case (f3)
                    3'd0:    op = ALU_SB;
                    3'd1:    op = ALU_SH;
                    3'd2:    op = ALU_SW;
                    default: ok = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                {use1, use2} = 2'b11;    // target computed in execute
                case (f3)
                    3'd0:    op = ALU_BEQ;
                    3'd1:    op = ALU_BNE;
                    3'd4:    op = ALU_BLT;
                    3'd5:    op = ALU_BGE;
                    3'd6:    op = ALU_BLTU;
                    3'd7:    op = ALU_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            default: ok = 1'b0;
        endcase
        r = '0;
        if (ok) begin
            r.ex.op1 = forward_ref(use1, w[19:15], imm1, exf, memf, exop, hz1);
            r.ex.op2 = forward_ref(use2, w[24:20], imm2, exf, memf, exop, hz2);
            r.stall  = hz1 | hz2;
            r.rs1.re   = use1;
            r.rs1.addr = use1 ? w[19:15] : '0;
            r.rs2.re   = use2;
            r.rs2.addr = use2 ? w[24:20] : '0;
            r.ex.aluop   = aluop_e'(op);
            r.ex.alusel  = alusel_e'(sel);
            r.ex.wreg    = wreg;
            r.ex.wd      = wreg ? w[11:7] : '0;
            r.ex.inst_ok = 1'b1;
        end
        if (r.stall) begin
            r.ex = '0;    // bubble
        end else begin
            r.ex.pc   = pc_v;
            r.ex.inst = w;
        end
        return r;
    endfunction

    task automatic fail_run();
        err_cnt++;
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_id_ex(input id_ex_t e);
        check_value("id_ex_o.pc", id_ex.pc, e.pc);
        check_value("id_ex_o.inst", id_ex.inst, e.inst);
        check_value("id_ex_o.aluop", id_ex.aluop, e.aluop);
        check_value("id_ex_o.alusel", id_ex.alusel, e.alusel);
        check_value("id_ex_o.op1", id_ex.op1, e.op1);
        check_value("id_ex_o.op2", id_ex.op2, e.op2);
        check_value("id_ex_o.wd", id_ex.wd, e.wd);
        check_value("id_ex_o.wreg", id_ex.wreg, e.wreg);
        check_value("id_ex_o.inst_ok", id_ex.inst_ok, e.inst_ok);
    endtask

    // one vector per cycle, 1 ns after the rising edge
    task automatic apply(input word_t pc_v, input word_t inst_v, input fwd_src_t exf,
                         input fwd_src_t memf, input aluop_e exop);
        @(posedge clk);
        #1;
        pc       = pc_v;
        inst     = inst_v;
        ex_fwd   = exf;
        mem_fwd  = memf;
        ex_aluop = exop;
        prev_exp = cur_exp;
        prev_v   = cur_v;
        cur_exp  = expected_decode(pc_v, inst_v, exf, memf, exop);
        cur_v    = 1'b1;
    endtask

    // stall and read requests for the current vector, id_ex_o for the one before
    always @(negedge clk) begin
        if (cur_v) begin
            assert (stall === cur_exp.stall) else begin
                $display("MISMATCH stall_o: got %0h expected %0h", stall, cur_exp.stall);
                fail_run();
            end
            check_value("rs1_rd_o", rs1_rd, cur_exp.rs1);
            check_value("rs2_rd_o", rs2_rd, cur_exp.rs2);
        end
        if (prev_v)
            compare_id_ex(prev_exp.ex);
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            fail_run();
        end
    end

    task automatic forwarding_cases();
        word_t w;
        w = enc_r(7'h00, 5'd4, 5'd3, F3_ADD, 5'd5, OPC_OP);    // add x5, x3, x4
        apply(32'h0000_0100, w, make_fwd(1'b1, 5'd3, 32'haaaa_0003),
              make_fwd(1'b1, 5'd3, 32'hbbbb_0003), ALU_ADD);
        apply(32'h0000_0104, w, NO_FWD, make_fwd(1'b1, 5'd4, 32'hbbbb_0004), ALU_NONE);
        apply(32'h0000_0108, w, make_fwd(1'b0, 5'd4, 32'haaaa_0004),
              make_fwd(1'b1, 5'd4, 32'hbbbb_1004), ALU_XOR);
        w = enc_r(7'h00, 5'd0, 5'd0, F3_ADD, 5'd6, OPC_OP);    // x0 sources
        apply(32'h0000_010c, w, make_fwd(1'b1, 5'd0, 32'haaaa_0000),
              make_fwd(1'b1, 5'd0, 32'hbbbb_0000), ALU_ADD);
    endtask

    task automatic load_use_cases();
        word_t w;
        w = enc_r(7'h00, 5'd9, 5'd2, F3_ADD, 5'd7, OPC_OP);    // add x7, x2, x9
        apply(32'h0000_0200, w, make_fwd(1'b1, 5'd2, 32'hdead_0002), NO_FWD, ALU_LW);
        apply(32'h0000_0200, w, NO_FWD, make_fwd(1'b1, 5'd2, 32'hdead_0002), ALU_NONE);
        apply(32'h0000_0204, w, make_fwd(1'b1, 5'd9, 32'h0bad_0009), NO_FWD, ALU_LBU);
        apply(32'h0000_0204, w, make_fwd(1'b1, 5'd9, 32'h1234_5678), NO_FWD, ALU_SUB);
    endtask

    // all funct3 values, legal and unused
    task automatic mem_op_cases();
        for (int f = 0; f < 8; f++) begin
            apply(32'h0000_1000 + 16 * f, enc_i(12'h7f0, 5'd6, 3'(f), 5'd11, OPC_LOAD),
                  NO_FWD, NO_FWD, ALU_NONE);
            apply(32'h0000_1004 + 16 * f, enc_r(7'h15, 5'd12, 5'd6, 3'(f), 5'd3, OPC_STORE),
                  NO_FWD, NO_FWD, ALU_NONE);
            apply(32'h0000_1008 + 16 * f, enc_r(7'h40, 5'd13, 5'd14, 3'(f), 5'd8, OPC_BRANCH),
                  NO_FWD, NO_FWD, ALU_NONE);
        end
    endtask

    task automatic illegal_cases();
        logic [6:0] bad_opc [6] = '{7'b0001111, 7'b1101111, 7'b1100111,
                                    7'b1110011, 7'b0000000, 7'b1111111};
        for (int k = 0; k < 6; k++)
            apply(32'h0000_2000 + 4 * k, {25'(take_bits(25)), bad_opc[k]},
                  NO_FWD, NO_FWD, ALU_NONE);
    endtask

    initial begin
        word_t    pc_r;
        word_t    inst_r;
        fwd_src_t exf;
        fwd_src_t memf;
        aluop_e   exop;
        pc       = '0;
        inst     = '0;
        ex_fwd   = '0;
        mem_fwd  = '0;
        ex_aluop = ALU_NONE;
        rst_n    = 1'b1;
        #1 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        #1;
        assert (id_ex === '0 && stall === 1'b0) else begin
            $display("id_ex_o is not a bubble or stall_o is high after reset");
            fail_run();
        end
        for (int n = 0; n < NUM_PLAIN; n++) begin
            pc_r = take_bits(30) << 2;
            apply(pc_r, gen_inst(1'b0), NO_FWD, NO_FWD, ALU_NONE);
        end
        forwarding_cases();
        load_use_cases();
        mem_op_cases();
        illegal_cases();
        for (int n = 0; n < NUM_FWD; n++) begin
            pc_r   = take_bits(30) << 2;
            inst_r = gen_inst(1'b1);
            exf    = make_fwd(1'(take_bits(1)), 5'(take_bits(2)), take_bits(32));
            memf   = make_fwd(1'(take_bits(1)), 5'(take_bits(2)), take_bits(32));
            exop   = aluop_e'(5'(take_bits(5) % 26));
            apply(pc_r, inst_r, exf, memf, exop);
        end
        apply('0, '0, NO_FWD, NO_FWD, ALU_NONE);    // pushes out the last vector
        @(negedge clk);
        #1;
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire
